// File: lsu_settings.svh
// Widths and bus encodings for the load/store unit.
// Included by the package and by any RTL file that uses the size
// or transfer codes directly.

`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// ====================
// Widths
// ====================
`define LSU_XLEN        32
`define LSU_REG_IDX_W   5

// ====================
// AHB encodings
// ====================
// Access size, same values as hsize
`define LSU_SIZE_BYTE   2'd0
`define LSU_SIZE_HALF   2'd1
`define LSU_SIZE_WORD   2'd2

`define LSU_HTRANS_IDLE   2'b00
`define LSU_HTRANS_NONSEQ 2'b10

`endif

// File: lsu_pkg.sv
// Shared types of the load/store unit.
// Holds the vector typedefs, the AHB transfer enum and the structs
// that carry requests, data-phase context and responses.

`include "lsu_settings.svh"

package lsu_pkg;

   // ====================
   // Plain vectors
   // ====================
   typedef logic [`LSU_XLEN-1:0]      word_t;
   typedef logic [`LSU_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [1:0]                acc_size_t;
   // Byte lane within a word
   typedef logic [1:0]                byte_off_t;

   // AHB transfer type, only the two used codes
   typedef enum logic [1:0] {
      HTRANS_IDLE   = `LSU_HTRANS_IDLE,
      HTRANS_NONSEQ = `LSU_HTRANS_NONSEQ
   } htrans_e;

   // ====================
   // Structs
   // ====================
   // One access from the core
   typedef struct packed {
      logic      is_store;
      acc_size_t size;
      logic      is_unsigned;
      word_t     addr;
      word_t     wdata;
      reg_idx_t  rd;
   } lsu_req_t;

   // What the data phase needs to remember about its access
   typedef struct packed {
      logic      valid;
      logic      is_store;
      acc_size_t size;
      logic      is_unsigned;
      byte_off_t offset;
      reg_idx_t  rd;
   } lsu_ctx_t;

   // Result handed back to the core
   typedef struct packed {
      logic     is_store;
      reg_idx_t rd;
      word_t    rdata;
      logic     err;
   } lsu_rsp_t;

endpackage

// File: lsu_lane_align.sv
// Byte lane steering for the data port.
// Store side moves the low byte or halfword of the store data into the
// lane given by the address; load side picks the lane of the current
// data phase out of hrdata and sign- or zero-extends it.
// Purely combinational, written for a 32-bit bus.

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_lane_align (
   input  lsu_pkg::acc_size_t st_size,
   input  lsu_pkg::byte_off_t st_offset,
   input  lsu_pkg::word_t     st_data,
   input  lsu_pkg::lsu_ctx_t  ctx,
   input  lsu_pkg::word_t     hrdata,
   output lsu_pkg::word_t     store_placed,
   output lsu_pkg::word_t     load_value
);

   import lsu_pkg::*;

   logic [7:0]  load_byte;
   logic [15:0] load_half;
   logic        fill;

   // ====================
   // Store placement
   // ====================
   always_comb begin
      case (st_size)
         `LSU_SIZE_BYTE: begin
            case (st_offset)
               2'd0:    store_placed = {24'b0, st_data[7:0]};
               2'd1:    store_placed = {16'b0, st_data[7:0], 8'b0};
               2'd2:    store_placed = {8'b0, st_data[7:0], 16'b0};
               default: store_placed = {st_data[7:0], 24'b0};
            endcase
         end
         `LSU_SIZE_HALF: begin
            // Bit 0 of the offset is zero for an aligned halfword
            if (st_offset[1]) begin
               store_placed = {st_data[15:0], 16'b0};
            end else begin
               store_placed = {16'b0, st_data[15:0]};
            end
         end
         default: begin
            store_placed = st_data;
         end
      endcase
   end

   // ====================
   // Load extraction
   // ====================
   // Selected lane moved down to bit 0
   always_comb begin
      case (ctx.offset)
         2'd0:    load_byte = hrdata[7:0];
         2'd1:    load_byte = hrdata[15:8];
         2'd2:    load_byte = hrdata[23:16];
         default: load_byte = hrdata[31:24];
      endcase
   end

   assign load_half = ctx.offset[1] ? hrdata[31:16] : hrdata[15:0];

   // Extension bit, zero for unsigned loads
   always_comb begin
      case (ctx.size)
         `LSU_SIZE_BYTE: fill = ~ctx.is_unsigned & load_byte[7];
         `LSU_SIZE_HALF: fill = ~ctx.is_unsigned & load_half[15];
         default:        fill = 1'b0;
      endcase
   end

   always_comb begin
      case (ctx.size)
         `LSU_SIZE_BYTE: begin
            load_value = {{24{fill}}, load_byte};
         end
         `LSU_SIZE_HALF: begin
            load_value = {{16{fill}}, load_half};
         end
         default: begin
            load_value = hrdata;
         end
      endcase
   end

endmodule

// File: lsu_addr_phase.sv
// Address phase of the AHB-lite data port.
// Drives haddr, htrans, hwrite and hsize straight from the core request
// and stalls the core through req_ready while the slave inserts waits.
// On acceptance the data-phase context and the lane-placed store word
// are registered for the following data phase.

`timescale 1ns/1ps

`include "lsu_settings.svh"

module lsu_addr_phase (
   input  logic               clk,
   input  logic               rst_n,
   input  logic               req_valid,
   input  lsu_pkg::lsu_req_t  req,
   input  logic               hready,
   input  lsu_pkg::word_t     store_placed,
   output logic               req_ready,
   output lsu_pkg::word_t     haddr,
   output lsu_pkg::htrans_e   htrans,
   output logic               hwrite,
   output lsu_pkg::acc_size_t hsize,
   output lsu_pkg::word_t     hwdata,
   output lsu_pkg::lsu_ctx_t  ctx
);

   import lsu_pkg::*;

   logic accept;

   // ====================
   // Address phase
   // ====================
   // A wait state on the previous data phase also stretches this one
   assign req_ready = hready;
   assign accept    = req_valid & hready;

   assign htrans = req_valid ? HTRANS_NONSEQ : HTRANS_IDLE;
   assign haddr  = req.addr;
   assign hwrite = req.is_store;
   assign hsize  = req.size;

   // ====================
   // Data-phase context
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctx <= '0;
      end else if (hready) begin
         ctx.valid <= accept;
         if (accept) begin
            ctx.is_store    <= req.is_store;
            ctx.size        <= req.size;
            ctx.is_unsigned <= req.is_unsigned;
            ctx.offset      <= req.addr[1:0];
            ctx.rd          <= req.rd;
         end
      end
   end

   // Store word, already in its lanes, held through the data phase
   always_ff @(posedge clk) begin
      if (accept) begin
         hwdata <= store_placed;
      end
   end

   // ====================
   // Checks
   // ====================
   // Misaligned accesses are not handled by the lane logic
   a_aligned: assert property (
      @(posedge clk) disable iff (!rst_n)
      accept |-> !(req.size == `LSU_SIZE_HALF && req.addr[0]) &&
                 !(req.size == `LSU_SIZE_WORD && req.addr[1:0] != 2'b00))
      else $error("misaligned access accepted at %h", req.addr);

   a_size_legal: assert property (
      @(posedge clk) disable iff (!rst_n)
      req_valid |-> req.size inside {`LSU_SIZE_BYTE, `LSU_SIZE_HALF, `LSU_SIZE_WORD})
      else $error("illegal access size %0d", req.size);

   // Core must hold a stalled request
   a_req_hold: assert property (
      @(posedge clk) disable iff (!rst_n)
      req_valid && !hready |=> req_valid && $stable(req))
      else $error("request changed or dropped during a wait state");

endmodule

// File: lsu_resp_out.sv
// Response side of the load/store unit.
// Closes the data phase on the first edge with hready high and registers
// one response per access, carrying the register index, the extended
// load value and the bus error flag.

`timescale 1ns/1ps

module lsu_resp_out (
   input  logic              clk,
   input  logic              rst_n,
   input  lsu_pkg::lsu_ctx_t ctx,
   input  logic              hready,
   input  logic              hresp,
   input  lsu_pkg::word_t    load_value,
   output logic              rsp_valid,
   output lsu_pkg::lsu_rsp_t rsp
);

   import lsu_pkg::*;

   logic  done;
   word_t rdata_nxt;

   // Data phase completes here
   assign done = ctx.valid & hready;

   // No data is returned on stores or on a failed transfer
   assign rdata_nxt = (ctx.is_store | hresp) ? '0 : load_value;

   // ====================
   // Response register
   // ====================
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rsp_valid <= 1'b0;
      end else begin
         rsp_valid <= done;
      end
   end

   always_ff @(posedge clk) begin
      if (done) begin
         rsp.is_store <= ctx.is_store;
         rsp.rd       <= ctx.rd;
         rsp.rdata    <= rdata_nxt;
         rsp.err      <= hresp;
      end
   end

   // ====================
   // Checks
   // ====================
   // Two-cycle AHB error response, first cycle with hready low
   a_err_two_cycle: assert property (
      @(posedge clk) disable iff (!rst_n)
      ctx.valid && hresp && hready |-> $past(hresp && !hready))
      else $error("error response without its wait cycle");

endmodule

// File: lsu_top.sv
// Load/store unit between the core and an AHB-lite data port.
// The core hands over one request at a time; address and data phases
// of neighbouring accesses overlap, and each access returns one response
// in request order.

`timescale 1ns/1ps

module lsu_top (
   input  logic               clk,
   input  logic               rst_n,
   // Core side
   input  logic               req_valid,
   input  lsu_pkg::lsu_req_t  req,
   output logic               req_ready,
   output logic               rsp_valid,
   output lsu_pkg::lsu_rsp_t  rsp,
   // AHB-lite master
   output lsu_pkg::word_t     haddr,
   output lsu_pkg::htrans_e   htrans,
   output logic               hwrite,
   output lsu_pkg::acc_size_t hsize,
   output lsu_pkg::word_t     hwdata,
   input  lsu_pkg::word_t     hrdata,
   input  logic               hready,
   input  logic               hresp
);

   import lsu_pkg::*;

   lsu_ctx_t ctx;
   word_t    store_placed;
   word_t    load_value;

   lsu_addr_phase u_addr_phase (
      .clk          (clk),
      .rst_n        (rst_n),
      .req_valid    (req_valid),
      .req          (req),
      .hready       (hready),
      .store_placed (store_placed),
      .req_ready    (req_ready),
      .haddr        (haddr),
      .htrans       (htrans),
      .hwrite       (hwrite),
      .hsize        (hsize),
      .hwdata       (hwdata),
      .ctx          (ctx)
   );

   // Store side works on the live request, load side on the context
   lsu_lane_align u_lane_align (
      .st_size      (req.size),
      .st_offset    (req.addr[1:0]),
      .st_data      (req.wdata),
      .ctx          (ctx),
      .hrdata       (hrdata),
      .store_placed (store_placed),
      .load_value   (load_value)
   );

   lsu_resp_out u_resp_out (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctx        (ctx),
      .hready     (hready),
      .hresp      (hresp),
      .load_value (load_value),
      .rsp_valid  (rsp_valid),
      .rsp        (rsp)
   );

endmodule

// File: tb_ahb_mem.sv
// AHB-lite slave memory for the load/store unit testbench.
// Sixteen preloaded words, 0 to 2 random wait states per transfer,
// lane-accurate writes and a two-cycle error response from 0x100 up.

`timescale 1ns/1ps

`include "lsu_settings.svh"

module tb_ahb_mem (
   input  logic               clk,
   input  logic               rst_n,
   input  lsu_pkg::word_t     haddr,
   input  lsu_pkg::htrans_e   htrans,
   input  logic               hwrite,
   input  lsu_pkg::acc_size_t hsize,
   input  lsu_pkg::word_t     hwdata,
   output lsu_pkg::word_t     hrdata,
   output logic               hready,
   output logic               hresp
);

   import lsu_pkg::*;

   localparam word_t ERR_BASE = 32'h0000_0100;

   word_t       mem [0:15];
   logic        dp_active;
   logic        dp_write;
   logic        dp_err;
   word_t       dp_addr;
   acc_size_t   dp_size;
   word_t       merged;
   int unsigned waits;
   int unsigned wait_draw;
   int unsigned rng_seed;
   bit          seeded;
   int          i;

   // Byte lanes touched by a write of this size and offset
   function automatic bit lane_enabled(input acc_size_t size, input byte_off_t off,
                                       input int lane);
      case (size)
         `LSU_SIZE_BYTE: return lane == off;
         `LSU_SIZE_HALF: return (lane / 2) == off[1];
         default:        return 1'b1;
      endcase
   endfunction

   initial begin
      seeded    = 1'b0;
      hready    = 1'b1;
      hresp     = 1'b0;
      dp_active = 1'b0;
      dp_write  = 1'b0;
      dp_err    = 1'b0;
   end

   // Read data follows the data-phase word, on writes too
   assign hrdata = dp_active ? mem[dp_addr[5:2]] : '0;

   always @(posedge clk or negedge rst_n) begin
      if (!seeded) begin
         rng_seed = 32'h7a86;
         rng_seed = $urandom(rng_seed);
         seeded   = 1'b1;
      end
      if (!rst_n) begin
         for (i = 0; i < 16; i++) begin
            mem[i] <= i * 32'h0101_0101 + 32'h8040_2010;
         end
         dp_active <= 1'b0;
         dp_err    <= 1'b0;
         waits     <= 0;
         hready    <= 1'b1;
         hresp     <= 1'b0;
      end else if (hready) begin
         // ====================
         // Close the data phase
         // ====================
         if (dp_active && dp_write && !dp_err) begin
            merged = mem[dp_addr[5:2]];
            for (i = 0; i < 4; i++) begin
               if (lane_enabled(dp_size, dp_addr[1:0], i)) begin
                  merged[i*8 +: 8] = hwdata[i*8 +: 8];
               end
            end
            mem[dp_addr[5:2]] <= merged;
         end
         // ====================
         // Next address phase
         // ====================
         if (htrans == HTRANS_NONSEQ) begin
            dp_active <= 1'b1;
            dp_write  <= hwrite;
            dp_addr   <= haddr;
            dp_size   <= hsize;
            if (haddr >= ERR_BASE) begin
               // First error cycle
               dp_err <= 1'b1;
               hready <= 1'b0;
               hresp  <= 1'b1;
            end else begin
               wait_draw = $urandom % 3;
               dp_err <= 1'b0;
               waits  <= wait_draw;
               hready <= (wait_draw == 0);
               hresp  <= 1'b0;
            end
         end else begin
            dp_active <= 1'b0;
            dp_err    <= 1'b0;
            hresp     <= 1'b0;
         end
      end else if (dp_err) begin
         // Second error cycle, hresp stays high
         hready <= 1'b1;
      end else if (waits <= 1) begin
         waits  <= 0;
         hready <= 1'b1;
      end else begin
         waits <= waits - 1;
      end
   end

endmodule

// File: tb_lsu.sv
// Testbench top for the load/store unit.
// Runs a table of loads and stores through the unit against an AHB-lite
// memory with random wait states and checks every response in order.

`timescale 1ns/1ps

`include "lsu_settings.svh"

module tb_lsu;

   import lsu_pkg::*;

   localparam int TIMEOUT_CYCLES = 20;

   // Request fields followed by the expected response
   typedef struct packed {
      logic      is_store;
      acc_size_t size;
      logic      is_unsigned;
      word_t     addr;
      word_t     wdata;
      reg_idx_t  rd;
      word_t     exp_rdata;
      logic      exp_err;
   } row_t;

   logic      clk = 1'b0;
   logic      rst_n;
   logic      req_valid;
   lsu_req_t  req;
   logic      req_ready;
   logic      rsp_valid;
   lsu_rsp_t  rsp;
   word_t     haddr;
   htrans_e   htrans;
   logic      hwrite;
   acc_size_t hsize;
   word_t     hwdata;
   word_t     hrdata;
   logic      hready;
   logic      hresp;

   row_t rows[$];
   int   pass_count  = 0;
   int   fail_count  = 0;
   int   timeouts    = 0;
   int   idle_errors = 0;

   always #50 clk = ~clk;

   lsu_top uut (.*);

   tb_ahb_mem slave (.*);

   task automatic add_row(input logic is_store, input acc_size_t size, input logic is_unsigned,
                          input word_t addr, input word_t wdata, input reg_idx_t rd,
                          input word_t exp_rdata, input logic exp_err);
      rows.push_back({is_store, size, is_unsigned, addr, wdata, rd, exp_rdata, exp_err});
   endtask

   // ====================
   // Stimulus table
   // ====================
   task automatic build_table();
      // Word store then load at the same address
      add_row(1, `LSU_SIZE_WORD, 0, 32'h00, 32'hDEAD_BEEF, 1, 32'h0, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h00, 32'h0, 2, 32'hDEAD_BEEF, 0);
      // Partial stores into words 1 to 3, then the merged words
      add_row(1, `LSU_SIZE_BYTE, 0, 32'h05, 32'hFFFF_FFA5, 3, 32'h0, 0);
      add_row(1, `LSU_SIZE_HALF, 0, 32'h06, 32'h7777_C3D2, 4, 32'h0, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h04, 32'h0, 5, 32'hC3D2_A511, 0);
      add_row(1, `LSU_SIZE_BYTE, 0, 32'h08, 32'h1234_565A, 6, 32'h0, 0);
      add_row(1, `LSU_SIZE_BYTE, 0, 32'h0B, 32'h0000_003C, 7, 32'h0, 0);
      add_row(1, `LSU_SIZE_BYTE, 0, 32'h0A, 32'hABCD_EF99, 8, 32'h0, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h08, 32'h0, 9, 32'h3C99_225A, 0);
      add_row(1, `LSU_SIZE_HALF, 0, 32'h0C, 32'hCAFE_BEEF, 10, 32'h0, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h0C, 32'h0, 11, 32'h8343_BEEF, 0);
      // Narrow loads from word 5, preloaded 0x85452515
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h14, 32'h0, 12, 32'h0000_0015, 0);
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h15, 32'h0, 13, 32'h0000_0025, 0);
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h16, 32'h0, 14, 32'h0000_0045, 0);
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h17, 32'h0, 15, 32'hFFFF_FF85, 0);
      add_row(0, `LSU_SIZE_BYTE, 1, 32'h17, 32'h0, 16, 32'h0000_0085, 0);
      add_row(0, `LSU_SIZE_HALF, 0, 32'h14, 32'h0, 17, 32'h0000_2515, 0);
      add_row(0, `LSU_SIZE_HALF, 0, 32'h16, 32'h0, 18, 32'hFFFF_8545, 0);
      add_row(0, `LSU_SIZE_HALF, 1, 32'h16, 32'h0, 19, 32'h0000_8545, 0);
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h05, 32'h0, 20, 32'hFFFF_FFA5, 0);
      // Error region; the store at 0x104 must leave word 1 alone
      add_row(0, `LSU_SIZE_WORD, 0, 32'h100, 32'h0, 21, 32'h0, 1);
      add_row(1, `LSU_SIZE_WORD, 0, 32'h104, 32'h1111_1111, 22, 32'h0, 1);
      add_row(0, `LSU_SIZE_BYTE, 0, 32'h1FF, 32'h0, 23, 32'h0, 1);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h04, 32'h0, 24, 32'hC3D2_A511, 0);
      add_row(1, `LSU_SIZE_WORD, 0, 32'h3C, 32'h0F0E_0D0C, 25, 32'h0, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h3C, 32'h0, 26, 32'h0F0E_0D0C, 0);
      add_row(0, `LSU_SIZE_WORD, 0, 32'h38, 32'h0, 27, 32'h8E4E_2E1E, 0);
   endtask

   task automatic check_idle();
      assert (htrans == HTRANS_IDLE && !rsp_valid) else begin
         $display("** Error at time %0t: bus not idle, htrans %b rsp_valid %b",
                  $time, htrans, rsp_valid);
         idle_errors++;
      end
   endtask

   task automatic report_mismatch(input int n, input string what, input word_t got,
                                  input word_t exp);
      $display("** Error at time %0t: row %0d %s is %h, expected %h", $time, n, what, got, exp);
   endtask

   // Rows back to back, each held until accepted
   task automatic send_rows();
      row_t r;
      int   n;
      int   cycles;
      bit   accepted;
      for (n = 0; n < rows.size(); n++) begin
         r         = rows[n];
         req       = {r.is_store, r.size, r.is_unsigned, r.addr, r.wdata, r.rd};
         req_valid = 1'b1;
         accepted  = 1'b0;
         cycles    = 0;
         // hready only moves on rising edges
         while (!accepted && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            accepted = req_ready;
            cycles++;
         end
         if (!accepted) begin
            $display("timeout: row %0d was never accepted by the unit", n);
            timeouts++;
            break;
         end
         @(posedge clk);
         #1;
      end
      req_valid = 1'b0;
   endtask

   // ====================
   // Response checker
   // ====================
   task automatic check_rows();
      row_t r;
      int   n;
      int   cycles;
      bit   seen;
      bit   row_ok;
      for (n = 0; n < rows.size(); n++) begin
         r      = rows[n];
         seen   = 1'b0;
         cycles = 0;
         while (!seen && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            seen = rsp_valid;
            cycles++;
         end
         if (!seen) begin
            $display("timeout: no response arrived for row %0d", n);
            timeouts++;
            break;
         end
         row_ok = 1'b1;
         assert (rsp.rd == r.rd) else begin
            report_mismatch(n, "rd", rsp.rd, r.rd);
            row_ok = 1'b0;
         end
         assert (rsp.is_store == r.is_store) else begin
            report_mismatch(n, "is_store", rsp.is_store, r.is_store);
            row_ok = 1'b0;
         end
         assert (rsp.rdata == r.exp_rdata) else begin
            report_mismatch(n, "rdata", rsp.rdata, r.exp_rdata);
            row_ok = 1'b0;
         end
         assert (rsp.err == r.exp_err) else begin
            report_mismatch(n, "err", rsp.err, r.exp_err);
            row_ok = 1'b0;
         end
         if (row_ok) begin
            pass_count++;
         end else begin
            fail_count++;
         end
         $display("row %0d: %s addr %h rd %0d %s", n, r.is_store ? "store" : "load",
                  r.addr, r.rd, row_ok ? "ok" : "mismatch");
      end
   endtask

   initial begin : main
      int i;
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      build_table();
      // Five rising edges in reset, bus checked between them
      @(posedge clk);
      for (i = 1; i < 5; i++) begin
         @(negedge clk);
         check_idle();
      end
      @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (i = 0; i < 3; i++) begin
         @(negedge clk);
         check_idle();
      end
      $display("idle bus check: %0d errors", idle_errors);
      @(posedge clk);
      #1;
      fork
         send_rows();
         check_rows();
      join
      // No stray response after the last row
      for (i = 0; i < 4; i++) begin
         @(negedge clk);
         assert (!rsp_valid) else begin
            $display("** Error at time %0t: response with no request left", $time);
            fail_count++;
         end
      end
      $display("rows passed %0d, rows failed %0d, timeouts %0d, idle errors %0d",
               pass_count, fail_count, timeouts, idle_errors);
      if (fail_count == 0 && timeouts == 0 && idle_errors == 0 &&
          pass_count == rows.size()) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// File: filelist.f
+incdir+.
lsu_pkg.sv
lsu_lane_align.sv
lsu_addr_phase.sv
lsu_resp_out.sv
lsu_top.sv
tb_ahb_mem.sv
tb_lsu.sv
